// File: design/rv_defs.svh
/* core-wide sizes and constants for the RV32I core
   include wherever a width, register count or reset address is needed */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define XLEN 32

// general registers, x0 included
`define REG_COUNT 32

`define RESET_PC 32'h8000_0000  // first fetch address

// sequential pc step
`define INST_BYTES 32'd4

`endif

// File: design/isa_pkg.sv
/* instruction set encodings of the RV32I subset: opcodes, formats,
   funct3 values and ALU operations, shared by decoder and execute */
`default_nettype none

package isa_pkg;

    typedef logic [2:0] funct3_t;

    // major opcodes the core executes, anything else retires as a no-op
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_n  // no operands, no write
    } inst_fmt_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // alu funct3 for op / op_imm
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
/* datapath types of the core: words, register indices, the decoded
   instruction, the retire record and the sequencer states */
`default_nettype none
`include "rv_defs.svh"

package core_pkg;
    import isa_pkg::*;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef struct packed {
        opcode_t   opcode;
        funct3_t   funct3;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        word_t     imm;     // already sign extended / shifted
        inst_fmt_t fmt;
        alu_op_t   alu_op;
        logic      we;      // rd write, low for x0
    } decoded_t;

    // one record per executed instruction
    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_exec
    } core_state_t;

endpackage

`default_nettype wire

// File: design/core_ctrl.sv
/* multi-cycle sequencer: issues one fetch, waits for the instruction,
   then runs a single execute cycle before fetching again */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl import core_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic imem_valid,
    output logic fetch_req,   // one-cycle request pulse
    output logic inst_load,
    output logic exec_en
);

    core_state_t state;
    core_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:  state_next = st_fetch;  // only left once after reset
            st_fetch: state_next = st_wait;
            st_wait: begin
                if (imem_valid) begin
                    state_next = st_exec;
                end
            end
            st_exec:  state_next = st_fetch;
            default:  state_next = st_idle;
        endcase
    end

    assign fetch_req = (state == st_fetch);
    // response only counts while waiting
    assign inst_load = (state == st_wait) && imem_valid;
    assign exec_en   = (state == st_exec);

endmodule

`default_nettype wire

// File: design/pc_unit.sv
/* program counter with reset address and next-pc selection,
   updated once per instruction at the end of execute */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module pc_unit import core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  exec_en,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t next_seq_pc
);

    assign next_seq_pc = pc + `INST_BYTES;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (exec_en) begin
            // taken branch or jump overrides the sequential step
            pc <= jump_en ? jump_target : next_seq_pc;
        end
    end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
/* holds the fetched instruction and decodes it combinationally into
   fields, immediate, format, ALU operation and write enable */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import isa_pkg::*, core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     inst_load,
    input  word_t    inst,
    output decoded_t dec
);

    word_t     inst_q;
    opcode_t   opcode;
    funct3_t   funct3;
    logic      funct7_alt;  // funct7 bit 5, sub / sra select
    reg_idx_t  rd;
    inst_fmt_t fmt;
    alu_op_t   alu_op;
    word_t     imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_q <= '0;  // decodes as a no-op
        end else if (inst_load) begin
            inst_q <= inst;
        end
    end

    assign opcode     = opcode_t'(inst_q[6:0]);
    assign funct3     = inst_q[14:12];
    assign funct7_alt = inst_q[30];
    assign rd         = inst_q[11:7];

    always_comb begin
        case (opcode)
            opc_op:               fmt = fmt_r;
            opc_op_imm, opc_jalr: fmt = fmt_i;
            opc_branch:           fmt = fmt_b;
            opc_lui, opc_auipc:   fmt = fmt_u;
            opc_jal:              fmt = fmt_j;
            default:              fmt = fmt_n;
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i:   imm = {{20{inst_q[31]}}, inst_q[31:20]};
            fmt_b:   imm = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
            fmt_u:   imm = {inst_q[31:12], 12'b0};
            fmt_j:   imm = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // everything outside op / op_imm just needs an adder
    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                f3_add_sub: alu_op = (fmt == fmt_r && funct7_alt) ? alu_sub : alu_add;
                f3_sll:     alu_op = alu_sll;
                f3_slt:     alu_op = alu_slt;
                f3_sltu:    alu_op = alu_sltu;
                f3_xor:     alu_op = alu_xor;
                f3_srl_sra: alu_op = funct7_alt ? alu_sra : alu_srl;
                f3_or:      alu_op = alu_or;
                f3_and:     alu_op = alu_and;
                default:    alu_op = alu_add;
            endcase
        end
    end

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = funct3;
        dec.rs1    = inst_q[19:15];
        dec.rs2    = inst_q[24:20];
        dec.rd     = rd;
        dec.imm    = imm;
        dec.fmt    = fmt;
        dec.alu_op = alu_op;
        // branches and unknown opcodes never write, nor does x0
        dec.we     = (fmt inside {fmt_r, fmt_i, fmt_u, fmt_j}) && (rd != '0);
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
/* general register file: two combinational read ports and one write
   port that commits on the clock edge */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: design/exec_unit.sv
/* execute stage: operand select, ALU, branch compare, jump target and
   write-back value, all in one combinational pass */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import isa_pkg::*, core_pkg::*; (
    input  decoded_t dec,
    input  word_t    pc,
    input  word_t    next_seq_pc,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output word_t    wdata,
    output logic     jump_en,
    output word_t    jump_target
);

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic [4:0] shamt;
    logic       branch_taken;

    always_comb begin
        case (dec.fmt)
            fmt_r: begin
                alu_a = rs1_val;
                alu_b = rs2_val;
            end
            fmt_i: begin
                alu_a = rs1_val;   // op_imm and jalr base
                alu_b = dec.imm;
            end
            fmt_u: begin
                alu_a = (dec.opcode == opc_lui) ? '0 : pc;
                alu_b = dec.imm;
            end
            fmt_b, fmt_j: begin
                alu_a = pc;        // pc-relative target
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_val;
                alu_b = rs2_val;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_result = alu_a + alu_b;
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << shamt;
            alu_slt:  alu_result = word_t'($signed(alu_a) < $signed(alu_b));
            alu_sltu: alu_result = word_t'(alu_a < alu_b);
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> shamt;
            alu_sra:  alu_result = $signed(alu_a) >>> shamt;
            alu_or:   alu_result = alu_a | alu_b;
            alu_and:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // compares use the register values, the ALU is busy with the target
    always_comb begin
        case (dec.funct3)
            f3_beq:  branch_taken = (rs1_val == rs2_val);
            f3_bne:  branch_taken = (rs1_val != rs2_val);
            f3_blt:  branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            f3_bltu: branch_taken = (rs1_val < rs2_val);
            f3_bgeu: branch_taken = (rs1_val >= rs2_val);
            default: branch_taken = 1'b0;
        endcase
    end

    assign jump_en = (dec.opcode == opc_jal) || (dec.opcode == opc_jalr) ||
                     ((dec.opcode == opc_branch) && branch_taken);

    assign jump_target = (dec.opcode == opc_jalr) ? {alu_result[31:1], 1'b0} : alu_result;

    // link address for jumps
    assign wdata = (dec.opcode == opc_jal || dec.opcode == opc_jalr) ? next_seq_pc : alu_result;

endmodule

`default_nettype wire

// File: design/rv_core.sv
/* top of the multi-cycle RV32I core: fetch port to instruction memory
   and a retire port reporting each executed instruction */
`timescale 1ns/1ps
`default_nettype none

module rv_core import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output logic    imem_req,
    output word_t   imem_addr,
    input  logic    imem_valid,
    input  word_t   imem_data,
    output logic    retire_valid,
    output retire_t retire
);

    logic     inst_load;
    logic     exec_en;
    logic     jump_en;
    word_t    jump_target;
    word_t    pc;
    word_t    next_seq_pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    wdata;
    decoded_t dec;

    core_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .imem_valid (imem_valid),
        .fetch_req  (imem_req),
        .inst_load  (inst_load),
        .exec_en    (exec_en)
    );

    pc_unit u_pc (
        .clk         (clk),
        .reset       (reset),
        .exec_en     (exec_en),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .next_seq_pc (next_seq_pc)
    );

    inst_decoder u_dec (
        .clk       (clk),
        .reset     (reset),
        .inst_load (inst_load),
        .inst      (imem_data),
        .dec       (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (exec_en && dec.we),  // commit only in execute
        .waddr  (dec.rd),
        .wdata  (wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    exec_unit u_exec (
        .dec         (dec),
        .pc          (pc),
        .next_seq_pc (next_seq_pc),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .wdata       (wdata),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    assign imem_addr    = pc;
    assign retire_valid = exec_en;
    assign retire       = '{pc: pc, we: dec.we, rd: dec.rd, data: wdata};

endmodule

`default_nettype wire

// File: verif/rv_ref_model.svh
/* instruction-level model of the RV32I subset, with its own registers and pc
   include inside the testbench module after the package imports */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

`include "rv_defs.svh"

word_t ref_regs [`REG_COUNT];  // x0 is never written, so it stays zero
word_t ref_pc;

task automatic reset_reference();
    int i;
    for (i = 0; i < `REG_COUNT; i++) begin
        ref_regs[i] = '0;
    end
    ref_pc = 32'h8000_0000;
endtask

function automatic word_t arith_result(input logic [2:0] f3, input logic alt,
                                       input logic is_reg, input word_t x, input word_t y);
    case (f3)
        f3_add_sub: return (is_reg && alt) ? x - y : x + y;
        f3_sll:     return x << y[4:0];
        f3_slt:     return {31'b0, $signed(x) < $signed(y)};
        f3_sltu:    return {31'b0, x < y};
        f3_xor:     return x ^ y;
        f3_srl_sra: begin
            if (alt) begin
                return $signed(x) >>> y[4:0];
            end
            return x >> y[4:0];
        end
        f3_or:      return x | y;
        default:    return x & y;
    endcase
endfunction

function automatic logic branch_condition(input logic [2:0] f3, input word_t x,
                                          input word_t y);
    case (f3)
        f3_beq:  return x == y;
        f3_bne:  return x != y;
        f3_blt:  return $signed(x) < $signed(y);
        f3_bge:  return $signed(x) >= $signed(y);
        f3_bltu: return x < y;
        f3_bgeu: return x >= y;
        default: return 1'b0;
    endcase
endfunction

// executes one instruction and returns what the core should retire
task automatic execute_reference(input word_t inst, output retire_t exp);
    logic [6:0] opc;
    logic [2:0] f3;
    reg_idx_t   rd;
    word_t      x;
    word_t      y;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      next_pc;
    word_t      value;
    logic       writes;
    opc     = inst[6:0];
    f3      = inst[14:12];
    rd      = inst[11:7];
    x       = ref_regs[inst[19:15]];
    y       = ref_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u   = {inst[31:12], 12'b0};
    imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = ref_pc + 32'd4;
    value   = '0;
    writes  = 1'b0;
    case (opc)
        opc_op: begin
            writes = 1'b1;
            value  = arith_result(f3, inst[30], 1'b1, x, y);
        end
        opc_op_imm: begin
            writes = 1'b1;
            value  = arith_result(f3, inst[30], 1'b0, x, imm_i);
        end
        opc_lui: begin
            writes = 1'b1;
            value  = imm_u;
        end
        opc_auipc: begin
            writes = 1'b1;
            value  = ref_pc + imm_u;
        end
        opc_branch: begin
            if (branch_condition(f3, x, y)) begin
                next_pc = ref_pc + imm_b;
            end
        end
        opc_jal: begin
            writes  = 1'b1;
            value   = ref_pc + 32'd4;
            next_pc = ref_pc + imm_j;
        end
        opc_jalr: begin
            writes  = 1'b1;
            value   = ref_pc + 32'd4;
            next_pc = (x + imm_i) & ~32'd1;  // low bit dropped
        end
        default: ;  // unknown opcode only steps the pc
    endcase
    exp = '{pc: ref_pc, we: writes && (rd != 5'd0), rd: rd, data: value};
    if (exp.we) begin
        ref_regs[rd] = value;
    end
    ref_pc = next_pc;
endtask

`endif

// File: verif/rv_core_tb.sv
/* testbench for the RV32I core: LFSR-built instructions served with random
   fetch latency, each retire checked against the reference model */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_tb import isa_pkg::*, core_pkg::*; ();

    localparam int total_insts = 156;
    localparam int cycle_limit = 16 + total_insts * 8 + 64;
    localparam int kind_alu    = 0;
    localparam int kind_upper  = 1;
    localparam int kind_branch = 2;
    localparam int kind_jump   = 3;
    localparam int kind_x0     = 4;

    logic    clk;
    logic    reset;
    logic    imem_req;
    word_t   imem_addr;
    logic    imem_valid;
    word_t   imem_data;
    logic    retire_valid;
    retire_t retire;

    logic [31:0] lfsr_state = 32'h840c_8fa1;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          insts_run = 0;
    int          tests_run = 0;
    int          test_start_errors;
    string       test_name;

    `include "rv_ref_model.svh"

    rv_core dut (
        .clk          (clk),
        .reset        (reset),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_valid   (imem_valid),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: core stopped fetching or retiring after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // registers kept to x0..x15 so results get reused
    function automatic reg_idx_t random_reg();
        return reg_idx_t'(random_bits(4));
    endfunction

    function automatic word_t alu_instruction();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        f3  = 3'(random_bits(3));
        alt = lfsr_bit();
        imm = 12'(random_bits(12));
        if (lfsr_bit()) begin
            alt = alt && (f3 == f3_add_sub || f3 == f3_srl_sra);
            return {1'b0, alt, 5'b0, random_reg(), random_reg(), f3, random_reg(), opc_op};
        end
        if (f3 == f3_sll || f3 == f3_srl_sra) begin
            imm[11:5] = {1'b0, alt && (f3 == f3_srl_sra), 5'b0};  // legal shift encodings
        end
        return {imm, random_reg(), f3, random_reg(), opc_op_imm};
    endfunction

    function automatic word_t upper_instruction();
        return {20'(random_bits(20)), random_reg(), lfsr_bit() ? opc_lui : opc_auipc};
    endfunction

    function automatic word_t branch_instruction();
        logic [2:0] f3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        f3 = 3'(random_bits(3));
        if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = f3 | 3'b100;  // no branch on these two
        end
        rs1 = random_reg();
        rs2 = lfsr_bit() ? rs1 : random_reg();  // equal operands half the time
        return {7'(random_bits(7)), rs2, rs1, f3, 5'(random_bits(5)), opc_branch};
    endfunction

    function automatic word_t jump_instruction();
        if (lfsr_bit()) begin
            return {20'(random_bits(20)), random_reg(), opc_jal};
        end
        return {12'(random_bits(12)), random_reg(), 3'b000, random_reg(), opc_jalr};
    endfunction

    function automatic word_t x0_or_unknown_instruction();
        logic [6:0] opc;
        case (2'(random_bits(2)))
            2'd0: return {12'(random_bits(12)), random_reg(), f3_add_sub, 5'd0, opc_op_imm};
            2'd1: return {7'b0, random_reg(), 5'd0, f3_or, random_reg(), opc_op};  // reads x0
            default: begin
                opc = 7'(random_bits(7));
                if (opc inside {opc_op, opc_op_imm, opc_lui, opc_auipc, opc_branch,
                                opc_jal, opc_jalr}) begin
                    opc = 7'b0000011;  // load is not implemented
                end
                return {25'(random_bits(25)), opc};
            end
        endcase
    endfunction

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
        errors++;
    endtask

    // the request comes one cycle after reset or after the previous retire
    task automatic check_fetch();
        @(negedge clk);
        if (!imem_req) begin
            $display("%s: fetch request did not come on time", test_name);
            errors++;
        end
        while (!imem_req) begin
            if (retire_valid) begin
                $display("%s: retire seen with no fetch outstanding", test_name);
                errors++;
            end
            @(negedge clk);
        end
        checks++;
        if (imem_addr !== ref_pc) begin
            report_mismatch("fetch address", ref_pc, imem_addr);
        end
    endtask

    task automatic run_instruction(input word_t inst);
        int      delay;
        retire_t exp;
        check_fetch();
        delay = int'(random_bits(2));
        repeat (delay) begin
            @(negedge clk);
            if (imem_req || retire_valid) begin
                $display("%s: core went on before the instruction arrived", test_name);
                errors++;
            end
        end
        @(negedge clk);
        imem_valid = 1'b1;
        imem_data  = inst;
        @(negedge clk);
        imem_valid = 1'b0;
        imem_data  = random_bits(32);  // stale data the core must ignore
        execute_reference(inst, exp);
        insts_run++;
        checks++;
        if (!retire_valid) begin
            $display("%s: no retire one cycle after the instruction returned", test_name);
            errors++;
        end else begin
            if (retire.pc !== exp.pc) begin
                report_mismatch("retire pc", exp.pc, retire.pc);
            end
            if (retire.we !== exp.we) begin
                report_mismatch("write enable", word_t'(exp.we), word_t'(retire.we));
            end
            if (exp.we && retire.rd !== exp.rd) begin
                report_mismatch("rd", word_t'(exp.rd), word_t'(retire.rd));
            end
            if (exp.we && retire.data !== exp.data) begin
                report_mismatch("write data", exp.data, retire.data);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("%s: done, %0d errors", test_name, errors - test_start_errors);
    endtask

    task automatic run_batch(input int count, input int kind);
        word_t inst;
        repeat (count) begin
            case (kind)
                kind_alu:    inst = alu_instruction();
                kind_upper:  inst = upper_instruction();
                kind_branch: inst = branch_instruction();
                kind_jump:   inst = jump_instruction();
                default:     inst = x0_or_unknown_instruction();
            endcase
            run_instruction(inst);
        end
    endtask

    initial begin
        reset      = 1'b1;
        imem_valid = 1'b0;
        imem_data  = '0;
        reset_reference();
        start_test("reset_fetch");
        repeat (16) begin
            @(negedge clk);
            if (imem_req || retire_valid) begin
                $display("reset_fetch: fetch or retire while reset is high");
                errors++;
            end
        end
        reset = 1'b0;
        run_batch(2, kind_alu);  // first fetch must come from the reset pc
        finish_test();
        start_test("upper_imm");
        run_batch(20, kind_upper);
        finish_test();
        start_test("alu_ops");
        run_batch(60, kind_alu);
        finish_test();
        start_test("branches");
        run_batch(30, kind_branch);
        finish_test();
        start_test("jumps");
        run_batch(20, kind_jump);
        finish_test();
        start_test("x0_and_unknown");
        run_batch(24, kind_x0);
        check_fetch();  // next pc of the last instruction
        finish_test();
        $display("tests %0d, instructions %0d, checks %0d, errors %0d",
                 tests_run, insts_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
+incdir+verif
design/isa_pkg.sv
design/core_pkg.sv
design/core_ctrl.sv
design/pc_unit.sv
design/inst_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/rv_core.sv
verif/rv_core_tb.sv
